//--- icache_isa_pkg.sv
`default_nettype none

// instruction-set constants seen by the fetch port
package icache_isa_pkg;

    // one fetched instruction
    localparam int unsigned INST_W = 32;

    // fetch exception flag, one bit per returned word
    localparam int unsigned EXC_W = 1;

    // andi r0, r0, 0
    localparam logic [INST_W-1:0] INST_NOP = 32'h0340_0000;

endpackage

`default_nettype wire

//--- icache_types_pkg.sv
`default_nettype none

// request opcodes and controller states of the icache
package icache_types_pkg;

    // fetch port opcode
    typedef enum logic {
        op_fetch     = 1'b0,    // read one instruction word
        op_inv_index = 1'b1     // clear both ways of one set
    } cache_op_e;

    // lookup controller
    typedef enum logic [2:0] {
        st_idle   = 3'd0,
        st_lookup = 3'd1,       // tags valid from the way stores
        st_miss   = 3'd2,       // memory request out
        st_fill   = 3'd3,       // wait for memory ack to drop
        st_reply  = 3'd4        // answer from the fill buffer
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- icache_req_decode.sv
`default_nettype none

module icache_req_decode #(
    parameter int INDEX_WIDTH       = 6,
    parameter int WORD_OFFSET_WIDTH = 3,
    localparam int TAG_W            = 30 - INDEX_WIDTH - WORD_OFFSET_WIDTH
) (
    input  wire                             clk,
    input  wire                             rstn,
    input  wire                             i_req,
    input  wire  [31:0]                     i_addr,
    input  var   icache_types_pkg::cache_op_e i_op,
    input  wire                             i_reply,
    output logic                            o_ack,
    output logic                            o_start,
    output icache_types_pkg::cache_op_e     o_op,
    output logic [TAG_W-1:0]                o_tag,
    output logic [INDEX_WIDTH-1:0]          o_index,
    output logic [WORD_OFFSET_WIDTH-1:0]    o_word,
    output logic                            o_misaligned,
    output logic [INDEX_WIDTH-1:0]          o_rd_index
);

    logic busy;     // request in flight, no ack yet
    logic capture;

    // only take a new request with ack low and nothing pending
    assign capture = i_req && !busy && !o_ack;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy    <= 1'b0;
            o_ack   <= 1'b0;
            o_start <= 1'b0;
        end else begin
            o_start <= capture;
            if (capture) begin
                busy <= 1'b1;
            end else if (i_reply) begin
                busy <= 1'b0;
            end
            if (i_reply) begin
                o_ack <= 1'b1;
            end else if (!i_req) begin
                o_ack <= 1'b0;      // four-phase: requester let go
            end
        end
    end

    // request fields, held until the next capture
    always_ff @(posedge clk) begin
        if (capture) begin
            o_op    <= i_op;
            o_tag   <= i_addr[31 -: TAG_W];
            o_index <= i_addr[WORD_OFFSET_WIDTH+2 +: INDEX_WIDTH];
            // invalidate answers with word 0
            o_word  <= (i_op == icache_types_pkg::op_fetch) ?
                       i_addr[2 +: WORD_OFFSET_WIDTH] : '0;
            o_misaligned <= (i_op == icache_types_pkg::op_fetch) && (i_addr[1:0] != 2'b00);
        end
    end

    // arrays see the new index on the capture edge itself
    assign o_rd_index = capture ? i_addr[WORD_OFFSET_WIDTH+2 +: INDEX_WIDTH] : o_index;

    // a start while ack is still up would overlap two transactions
    a_start_not_during_ack: assert property (
        @(posedge clk) disable iff (!rstn)
        o_start |-> !o_ack
    );

endmodule

`default_nettype wire

//--- icache_way_store.sv
`default_nettype none

module icache_way_store #(
    parameter int INDEX_WIDTH       = 6,
    parameter int WORD_OFFSET_WIDTH = 3,
    localparam int SETS             = 1 << INDEX_WIDTH,
    localparam int LINE_W           = 32 << WORD_OFFSET_WIDTH,
    localparam int TAG_W            = 30 - INDEX_WIDTH - WORD_OFFSET_WIDTH
) (
    input  wire                     clk,
    input  wire                     rstn,
    input  wire [INDEX_WIDTH-1:0]   i_rd_index,
    input  wire                     i_fill,
    input  wire [INDEX_WIDTH-1:0]   i_wr_index,
    input  wire [TAG_W-1:0]         i_wr_tag,
    input  wire [LINE_W-1:0]        i_wr_line,
    input  wire                     i_inv,
    input  wire [INDEX_WIDTH-1:0]   i_inv_index,
    output logic                    o_valid,
    output logic [TAG_W-1:0]        o_tag,
    output logic [LINE_W-1:0]       o_line
);

    logic [SETS-1:0]    valid;          // one bit per set, in flops
    logic [TAG_W-1:0]   tag_mem  [SETS];
    logic [LINE_W-1:0]  line_mem [SETS];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (i_fill) begin
            valid[i_wr_index] <= 1'b1;
        end else if (i_inv) begin
            valid[i_inv_index] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= valid[i_rd_index];   // same latency as the arrays
        end
    end

    // tag and line arrays, block ram style
    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_mem[i_wr_index]  <= i_wr_tag;
            line_mem[i_wr_index] <= i_wr_line;
        end
        o_tag  <= tag_mem[i_rd_index];
        o_line <= line_mem[i_rd_index];
    end

    // controller only fills in st_fill and invalidates in st_lookup
    a_fill_inv_exclusive: assert property (
        @(posedge clk) disable iff (!rstn)
        !(i_fill && i_inv)
    );

endmodule

`default_nettype wire

//--- icache_lookup_ctrl.sv
`default_nettype none

module icache_lookup_ctrl #(
    parameter int INDEX_WIDTH       = 6,
    parameter int WORD_OFFSET_WIDTH = 3,
    localparam int SETS             = 1 << INDEX_WIDTH,
    localparam int LINE_W           = 32 << WORD_OFFSET_WIDTH,
    localparam int TAG_W            = 30 - INDEX_WIDTH - WORD_OFFSET_WIDTH
) (
    input  wire                             clk,
    input  wire                             rstn,
    input  wire                             i_start,
    input  var   icache_types_pkg::cache_op_e i_op,
    input  wire  [TAG_W-1:0]                i_tag,
    input  wire  [INDEX_WIDTH-1:0]          i_index,
    input  wire                             i_misaligned,
    input  wire                             i_valid0,
    input  wire  [TAG_W-1:0]                i_tag0,
    input  wire                             i_valid1,
    input  wire  [TAG_W-1:0]                i_tag1,
    input  wire                             i_mem_ack,
    input  wire  [LINE_W-1:0]               i_mem_line,
    output logic                            o_mem_req,
    output logic [31:0]                     o_mem_addr,
    output logic                            o_fill0,
    output logic                            o_fill1,
    output logic                            o_inv,
    output logic [LINE_W-1:0]               o_fill_line,
    output logic                            o_reply,
    output logic                            o_from_fill,
    output logic                            o_hit_way
);

    icache_types_pkg::ctrl_state_e state, state_nxt;

    logic [SETS-1:0] lru;   // victim way per set, 0 after reset
    logic is_fetch;
    logic is_inv;
    logic hit0;
    logic hit1;
    logic hit;
    logic lookup_done;      // lookup answers without memory
    logic mem_done;         // line arrives this edge
    logic victim;

    assign is_fetch = (i_op == icache_types_pkg::op_fetch) && !i_misaligned;
    assign is_inv   = (i_op == icache_types_pkg::op_inv_index);

    assign hit0 = i_valid0 && (i_tag0 == i_tag);
    assign hit1 = i_valid1 && (i_tag1 == i_tag);
    assign hit  = is_fetch && (hit0 || hit1);

    assign lookup_done = i_misaligned || is_inv || hit;
    assign mem_done    = (state == icache_types_pkg::st_miss) && i_mem_ack;
    assign victim      = lru[i_index];

    always_comb begin
        state_nxt = state;
        case (state)
            icache_types_pkg::st_idle: begin
                if (i_start) begin
                    state_nxt = icache_types_pkg::st_lookup;
                end
            end
            icache_types_pkg::st_lookup: begin
                if (lookup_done) begin
                    state_nxt = icache_types_pkg::st_idle;
                end else begin
                    state_nxt = icache_types_pkg::st_miss;
                end
            end
            icache_types_pkg::st_miss: begin
                if (i_mem_ack) begin
                    state_nxt = icache_types_pkg::st_fill;
                end
            end
            icache_types_pkg::st_fill: begin
                if (!i_mem_ack) begin
                    state_nxt = icache_types_pkg::st_reply;  // memory side closed
                end
            end
            icache_types_pkg::st_reply: state_nxt = icache_types_pkg::st_idle;
            default: state_nxt = icache_types_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= icache_types_pkg::st_idle;
            lru         <= '0;
            o_fill0     <= 1'b0;
            o_fill1     <= 1'b0;
            o_reply     <= 1'b0;
            o_from_fill <= 1'b0;
            o_hit_way   <= 1'b0;
        end else begin
            state <= state_nxt;

            // hit way becomes most recent, other way is next victim
            if ((state == icache_types_pkg::st_lookup) && hit) begin
                lru[i_index] <= hit0;
            end else if (mem_done) begin
                lru[i_index] <= !victim;
            end

            // write the victim way one cycle after the line lands
            o_fill0 <= mem_done && !victim;
            o_fill1 <= mem_done && victim;

            o_reply <= ((state == icache_types_pkg::st_lookup) && lookup_done) ||
                       (state == icache_types_pkg::st_reply);
            o_from_fill <= (state == icache_types_pkg::st_reply);
            o_hit_way   <= hit && hit1;
        end
    end

    // fill buffer
    always_ff @(posedge clk) begin
        if (mem_done) begin
            o_fill_line <= i_mem_line;
        end
    end

    assign o_inv      = (state == icache_types_pkg::st_lookup) && is_inv;
    assign o_mem_req  = (state == icache_types_pkg::st_miss);
    assign o_mem_addr = {i_tag, i_index, {(WORD_OFFSET_WIDTH + 2){1'b0}}};   // line aligned

    // request and its line address stay put until memory answers
    a_mem_req_held: assert property (
        @(posedge clk) disable iff (!rstn)
        (o_mem_req && !i_mem_ack) |=> o_mem_req && $stable(o_mem_addr)
    );

    // a line lives in at most one way
    a_single_way_hit: assert property (
        @(posedge clk) disable iff (!rstn)
        (state == icache_types_pkg::st_lookup) |-> !(hit0 && hit1)
    );

endmodule

`default_nettype wire

//--- icache_word_select.sv
`default_nettype none

module icache_word_select #(
    parameter int INDEX_WIDTH       = 6,
    parameter int WORD_OFFSET_WIDTH = 3,
    localparam int LINE_W           = 32 << WORD_OFFSET_WIDTH
) (
    input  wire                                 clk,
    input  wire                                 rstn,
    input  wire                                 i_reply,
    input  wire                                 i_from_fill,
    input  wire                                 i_hit_way,
    input  wire                                 i_misaligned,
    input  wire [WORD_OFFSET_WIDTH-1:0]         i_word,
    input  wire [LINE_W-1:0]                    i_line0,
    input  wire [LINE_W-1:0]                    i_line1,
    input  wire [LINE_W-1:0]                    i_fill_line,
    output logic [icache_isa_pkg::INST_W-1:0]   o_data,
    output logic [icache_isa_pkg::EXC_W-1:0]    o_exc
);

    logic [LINE_W-1:0]                  src_line;
    logic [icache_isa_pkg::INST_W-1:0]  word;

    // fill buffer after a miss, else the way that hit
    assign src_line = i_from_fill ? i_fill_line : (i_hit_way ? i_line1 : i_line0);
    assign word     = src_line[i_word*32 +: 32];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_exc <= '0;
        end else if (i_reply) begin
            o_exc <= {icache_isa_pkg::EXC_W{i_misaligned}};
        end
    end

    // held through the whole ack phase
    always_ff @(posedge clk) begin
        if (i_reply) begin
            o_data <= i_misaligned ? icache_isa_pkg::INST_NOP : word;
        end
    end

    // reply is a one-cycle pulse, so o_data loads once per transaction
    a_reply_pulse: assert property (
        @(posedge clk) disable iff (!rstn)
        i_reply |=> !i_reply
    );

endmodule

`default_nettype wire

//--- icache_top.sv
`default_nettype none

module icache_top #(
    parameter int INDEX_WIDTH       = 6,
    parameter int WORD_OFFSET_WIDTH = 3,
    localparam int LINE_W           = 32 << WORD_OFFSET_WIDTH,
    localparam int TAG_W            = 30 - INDEX_WIDTH - WORD_OFFSET_WIDTH
) (
    input  wire                                 clk,
    input  wire                                 rstn,
    // fetch port
    input  wire                                 i_req,
    input  wire [31:0]                          i_addr,
    input  var  icache_types_pkg::cache_op_e    i_op,
    output logic                                o_ack,
    output logic [icache_isa_pkg::INST_W-1:0]   o_data,
    output logic [icache_isa_pkg::EXC_W-1:0]    o_exc,
    // memory port, one line per transfer
    output logic                                o_mem_req,
    output logic [31:0]                         o_mem_addr,
    input  wire                                 i_mem_ack,
    input  wire [LINE_W-1:0]                    i_mem_line
);

    icache_types_pkg::cache_op_e op;

    logic                           start;
    logic [TAG_W-1:0]               tag;
    logic [INDEX_WIDTH-1:0]         index;
    logic [WORD_OFFSET_WIDTH-1:0]   word;
    logic                           misaligned;
    logic [INDEX_WIDTH-1:0]         rd_index;
    logic                           valid0;
    logic                           valid1;
    logic [TAG_W-1:0]               tag0;
    logic [TAG_W-1:0]               tag1;
    logic [LINE_W-1:0]              line0;
    logic [LINE_W-1:0]              line1;
    logic                           fill0;
    logic                           fill1;
    logic                           inv;
    logic [LINE_W-1:0]              fill_line;
    logic                           reply;
    logic                           from_fill;
    logic                           hit_way;

    icache_req_decode #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) icache_req_decode_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_req        (i_req),
        .i_addr       (i_addr),
        .i_op         (i_op),
        .i_reply      (reply),
        .o_ack        (o_ack),
        .o_start      (start),
        .o_op         (op),
        .o_tag        (tag),
        .o_index      (index),
        .o_word       (word),
        .o_misaligned (misaligned),
        .o_rd_index   (rd_index)
    );

    icache_way_store #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) icache_way_store_0_i (
        .clk         (clk),
        .rstn        (rstn),
        .i_rd_index  (rd_index),
        .i_fill      (fill0),
        .i_wr_index  (index),
        .i_wr_tag    (tag),
        .i_wr_line   (fill_line),
        .i_inv       (inv),
        .i_inv_index (index),
        .o_valid     (valid0),
        .o_tag       (tag0),
        .o_line      (line0)
    );

    icache_way_store #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) icache_way_store_1_i (
        .clk         (clk),
        .rstn        (rstn),
        .i_rd_index  (rd_index),
        .i_fill      (fill1),
        .i_wr_index  (index),
        .i_wr_tag    (tag),
        .i_wr_line   (fill_line),
        .i_inv       (inv),         // index invalidate hits both ways
        .i_inv_index (index),
        .o_valid     (valid1),
        .o_tag       (tag1),
        .o_line      (line1)
    );

    icache_lookup_ctrl #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) icache_lookup_ctrl_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_start      (start),
        .i_op         (op),
        .i_tag        (tag),
        .i_index      (index),
        .i_misaligned (misaligned),
        .i_valid0     (valid0),
        .i_tag0       (tag0),
        .i_valid1     (valid1),
        .i_tag1       (tag1),
        .i_mem_ack    (i_mem_ack),
        .i_mem_line   (i_mem_line),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .o_fill0      (fill0),
        .o_fill1      (fill1),
        .o_inv        (inv),
        .o_fill_line  (fill_line),
        .o_reply      (reply),
        .o_from_fill  (from_fill),
        .o_hit_way    (hit_way)
    );

    icache_word_select #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) icache_word_select_i (
        .clk          (clk),
        .rstn         (rstn),
        .i_reply      (reply),
        .i_from_fill  (from_fill),
        .i_hit_way    (hit_way),
        .i_misaligned (misaligned),
        .i_word       (word),
        .i_line0      (line0),
        .i_line1      (line1),
        .i_fill_line  (fill_line),
        .o_data       (o_data),
        .o_exc        (o_exc)
    );

endmodule

`default_nettype wire

//--- tb_icache.sv
`default_nettype none

module tb_icache;

    localparam int INDEX_WIDTH       = 6;
    localparam int WORD_OFFSET_WIDTH = 3;
    localparam int WORDS             = 1 << WORD_OFFSET_WIDTH;
    localparam int LINE_W            = 32 * WORDS;
    localparam int OFFSET_BITS       = WORD_OFFSET_WIDTH + 2;
    localparam int TAG_W             = 30 - INDEX_WIDTH - WORD_OFFSET_WIDTH;
    localparam int unsigned RAND_SEED       = 42558;
    localparam int unsigned CYCLES_PER_TXN  = 200;

    logic                                   clk;
    logic                                   rstn;
    logic                                   i_req;
    logic [31:0]                            i_addr;
    icache_types_pkg::cache_op_e            i_op;
    logic                                   o_ack;
    logic [icache_isa_pkg::INST_W-1:0]      o_data;
    logic [icache_isa_pkg::EXC_W-1:0]       o_exc;
    logic                                   o_mem_req;
    logic [31:0]                            o_mem_addr;
    logic                                   i_mem_ack;
    logic [LINE_W-1:0]                      i_mem_line;

    int unsigned mem_requests = 0;      // line requests seen by the memory model
    int unsigned txn_count    = 0;      // fetch port transactions issued
    logic [31:0] last_mem_addr;

    icache_top #(
        .INDEX_WIDTH       (INDEX_WIDTH),
        .WORD_OFFSET_WIDTH (WORD_OFFSET_WIDTH)
    ) icache_top_i (
        .clk        (clk),
        .rstn       (rstn),
        .i_req      (i_req),
        .i_addr     (i_addr),
        .i_op       (i_op),
        .o_ack      (o_ack),
        .o_data     (o_data),
        .o_exc      (o_exc),
        .o_mem_req  (o_mem_req),
        .o_mem_addr (o_mem_addr),
        .i_mem_ack  (i_mem_ack),
        .i_mem_line (i_mem_line)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic report_error(input string msg);
        $display("** Error (%0t): %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "stopping on first error");
    endtask

    // word w of line a holds a + 4w
    function automatic logic [LINE_W-1:0] make_line(input logic [31:0] line_addr);
        logic [LINE_W-1:0] line;
        line = '0;
        for (int w = 0; w < WORDS; w++) begin
            line[w*32 +: 32] = line_addr + 32'(4 * w);
        end
        return line;
    endfunction

    function automatic logic [31:0] line_of(input logic [31:0] addr);
        return {addr[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return line_of(addr) + 32'(4 * addr[OFFSET_BITS-1:2]);
    endfunction

    function automatic logic [31:0] make_addr(input logic [TAG_W-1:0] tag,
                                              input logic [INDEX_WIDTH-1:0] index,
                                              input logic [WORD_OFFSET_WIDTH-1:0] word);
        return {tag, index, word, 2'b00};
    endfunction

    // memory side, answers each line request after 1 to 5 cycles
    initial begin : memory_model
        int unsigned delay;
        void'($urandom(RAND_SEED));
        i_mem_ack  <= 1'b0;
        i_mem_line <= '0;
        forever begin
            @(posedge clk);
            if (rstn && o_mem_req && !i_mem_ack) begin
                mem_requests++;
                last_mem_addr = o_mem_addr;
                assert (o_mem_addr[OFFSET_BITS-1:0] == '0) else
                    report_error($sformatf("memory address %h not line aligned", o_mem_addr));
                delay = 1 + ($urandom % 5);
                repeat (delay - 1) @(posedge clk);
                i_mem_ack  <= 1'b1;
                i_mem_line <= make_line(last_mem_addr);
                do @(posedge clk); while (o_mem_req);   // hold ack until req falls
                i_mem_ack  <= 1'b0;
            end
        end
    end

    // one four-phase transaction, hold_cycles keeps i_req up after the ack
    task automatic run_request(input logic [31:0] addr, input icache_types_pkg::cache_op_e op,
                               input int unsigned hold_cycles, output logic [31:0] data,
                               output logic exc, output int unsigned latency);
        int unsigned reqs_before;
        @(posedge clk);
        txn_count++;
        i_req  <= 1'b1;
        i_addr <= addr;
        i_op   <= op;
        latency = 0;
        @(posedge clk);     // first edge with i_req high
        do begin
            @(posedge clk);
            latency++;
            @(negedge clk);
        end while (!o_ack);
        data = o_data;
        exc  = o_exc[0];
        reqs_before = mem_requests;
        repeat (hold_cycles) begin
            @(posedge clk);
            i_addr <= addr ^ 32'h8000_0000;     // a second capture here would miss
            @(negedge clk);
            assert (o_ack) else
                report_error("o_ack dropped while i_req still high");
            assert (o_data == data && o_exc[0] == exc) else
                report_error($sformatf("o_data moved to %h during ack, held %h", o_data, data));
            assert (!o_mem_req && mem_requests == reqs_before) else
                report_error("memory request started while ack was held");
        end
        @(posedge clk);
        i_req <= 1'b0;
        do @(negedge clk); while (o_ack);
    endtask

    task automatic fetch_expect(input logic [31:0] addr, input int unsigned new_reqs,
                                input bit exact_latency, input int unsigned hold_cycles);
        logic [31:0] data;
        logic [31:0] exp;
        logic exc;
        int unsigned lat;
        int unsigned reqs_before;
        reqs_before = mem_requests;
        exp = expected_word(addr);
        run_request(addr, icache_types_pkg::op_fetch, hold_cycles, data, exc, lat);
        assert (data == exp) else
            report_error($sformatf("fetch %h returned %h, expected %h", addr, data, exp));
        assert (!exc) else
            report_error($sformatf("fetch %h raised an exception", addr));
        assert (mem_requests - reqs_before == new_reqs) else
            report_error($sformatf("fetch %h made %0d memory requests, expected %0d",
                                   addr, mem_requests - reqs_before, new_reqs));
        if (new_reqs != 0) begin
            assert (last_mem_addr == line_of(addr)) else
                report_error($sformatf("memory address %h for fetch %h", last_mem_addr, addr));
        end
        if (exact_latency) begin
            assert (lat == 3) else
                report_error($sformatf("fetch %h acked after %0d cycles, expected 3", addr, lat));
        end
    endtask

    task automatic cold_miss_then_hit();
        logic [31:0] base;
        base = 32'h0000_2040;
        fetch_expect(base, 1, 1'b0, 0);
        for (int w = 1; w < WORDS; w++) begin
            fetch_expect(base + 32'(4 * w), 0, 1'b1, 0);
        end
        fetch_expect(base, 0, 1'b1, 0);     // word 0 now hits too
    endtask

    task automatic misaligned_fetch();
        logic [31:0] addrs [2];
        logic [31:0] data;
        logic exc;
        int unsigned lat;
        int unsigned reqs_before;
        addrs[0] = 32'h0000_2042;   // line already cached
        addrs[1] = 32'h0001_0003;   // never fetched
        foreach (addrs[i]) begin
            reqs_before = mem_requests;
            run_request(addrs[i], icache_types_pkg::op_fetch, 0, data, exc, lat);
            assert (data == icache_isa_pkg::INST_NOP && exc) else
                report_error($sformatf("misaligned %h gave data %h exc %b", addrs[i], data, exc));
            assert (lat == 3) else
                report_error($sformatf("misaligned fetch acked after %0d cycles", lat));
            assert (mem_requests == reqs_before) else
                report_error("misaligned fetch went to memory");
        end
    endtask

    task automatic lru_replacement();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = make_addr(21'h00011, 6'd9, 3'd3);
        b = make_addr(21'h00022, 6'd9, 3'd5);
        c = make_addr(21'h00033, 6'd9, 3'd0);
        fetch_expect(a, 1, 1'b0, 0);
        fetch_expect(b, 1, 1'b0, 0);
        fetch_expect(a, 0, 1'b1, 0);    // a most recent, b is victim
        fetch_expect(c, 1, 1'b0, 0);
        fetch_expect(a, 0, 1'b1, 0);
        fetch_expect(b, 1, 1'b0, 0);
    endtask

    task automatic index_invalidate();
        logic [31:0] d;
        logic [31:0] e;
        logic [31:0] data;
        logic exc;
        int unsigned lat;
        int unsigned reqs_before;
        d = make_addr(21'h00101, 6'd12, 3'd1);
        e = make_addr(21'h00202, 6'd12, 3'd6);
        fetch_expect(d, 1, 1'b0, 0);
        fetch_expect(e, 1, 1'b0, 0);
        fetch_expect(d, 0, 1'b1, 0);
        fetch_expect(e, 0, 1'b1, 0);
        reqs_before = mem_requests;
        run_request(make_addr(21'h0, 6'd12, 3'd0), icache_types_pkg::op_inv_index, 0,
                    data, exc, lat);
        assert (lat == 3 && !exc) else
            report_error($sformatf("invalidate acked after %0d cycles, exc %b", lat, exc));
        assert (mem_requests == reqs_before) else
            report_error("invalidate went to memory");
        fetch_expect(d, 1, 1'b0, 0);    // both ways of the set are gone
        fetch_expect(e, 1, 1'b0, 0);
    endtask

    task automatic held_request();
        fetch_expect(32'h0000_2048, 0, 1'b1, 8);    // hit, req held 8 extra cycles
        fetch_expect(make_addr(21'h00404, 6'd20, 3'd2), 1, 1'b0, 7);
        fetch_expect(make_addr(21'h00404, 6'd20, 3'd7), 0, 1'b1, 0);
    endtask

    // limit grows with every transaction issued
    initial begin : watchdog
        int unsigned cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > CYCLES_PER_TXN * (txn_count + 1)) begin
                $display("Timeout: the cache stopped answering after %0d cycles", cycles);
                $display("Result: FAILED");
                $fatal(1, "watchdog expired");
            end
        end
    end

    initial begin : main
        rstn   <= 1'b0;
        i_req  <= 1'b0;
        i_addr <= '0;
        i_op   <= icache_types_pkg::op_fetch;
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        assert (!o_ack && !o_mem_req) else
            report_error("o_ack or o_mem_req high after reset");
        cold_miss_then_hit();
        misaligned_fetch();
        lru_replacement();
        index_invalidate();
        held_request();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- icache.f
icache_isa_pkg.sv
icache_types_pkg.sv
icache_req_decode.sv
icache_way_store.sv
icache_lookup_ctrl.sv
icache_word_select.sv
icache_top.sv
tb_icache.sv

//--- Makefile
TOP = tb_icache

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f icache.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean
